//--- sim.f
common/selftest_pkg.sv
source/selftest_ctrl.sv
source/selftest_cmd.sv
source/selftest_check.sv
source/ddr_selftest.sv
testbench/selftest_checker.sv
testbench/app_mem_model.sv
testbench/tb_ddr_selftest.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ddr_selftest
FILELIST = sim.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_ddr_selftest.sv
`timescale 1ns/1ps

module tb_ddr_selftest;
  import selftest_pkg::*;

  localparam int        HOLD_CYCLES = 200;
  localparam int        FAULT_IDX   = 21;        // burst that reads back corrupted
  localparam app_addr_t PART_START  = 29'h1000;
  localparam app_addr_t PART_END    = 29'h1110;  // 272 above start so three passes

  logic         W_uclk;
  logic         W_urst;
  logic         test_en;
  test_cfg_t    cfg;
  logic         init_done;
  app_req_t     app_req;
  app_wdf_t     app_wdf;
  logic         app_rdy;
  logic         app_wdf_rdy;
  app_rsp_t     app_rsp;
  test_status_e test_status;
  fail_info_t   fail_info;
  lane_map_t    err_lane_map;
  count_t       test_time;
  count_t       finish_cnt;
  logic [1:0]   stall;
  logic         stall_on;
  logic [31:0]  lcg_state;
  app_addr_t    fault_addr;
  app_data_t    fault_xor;

  test_mode_e   exp_mode;        // expectations of the running test
  word_t        exp_word;
  app_addr_t    exp_base;
  int           wr_seen;
  app_addr_t    first_wr_addr;

  string        cur_test;
  int           cur_errs;
  int           total_errs;
  int           tests_run;
  int           tests_failed;

  ddr_selftest dut0
  (
    .W_uclk       (W_uclk),
    .W_urst       (W_urst),
    .test_en      (test_en),
    .cfg          (cfg),
    .init_done    (init_done),
    .app_req      (app_req),
    .app_wdf      (app_wdf),
    .app_rdy      (app_rdy),
    .app_wdf_rdy  (app_wdf_rdy),
    .app_rsp      (app_rsp),
    .test_status  (test_status),
    .fail_info    (fail_info),
    .err_lane_map (err_lane_map),
    .test_time    (test_time),
    .finish_cnt   (finish_cnt)
  );

  app_mem_model mem0
  (
    .W_uclk      (W_uclk),
    .W_urst      (W_urst),
    .app_req     (app_req),
    .app_wdf     (app_wdf),
    .app_rdy     (app_rdy),
    .app_wdf_rdy (app_wdf_rdy),
    .app_rsp     (app_rsp),
    .stall       (stall),
    .fault_addr  (fault_addr),
    .fault_xor   (fault_xor)
  );

  bind ddr_selftest selftest_checker chk0
  (
    .W_uclk      (W_uclk),
    .W_urst      (W_urst),
    .state       (state),
    .fail        (fail),
    .app_req     (app_req),
    .app_wdf     (app_wdf),
    .app_rdy     (app_rdy),
    .app_wdf_rdy (app_wdf_rdy)
  );

  initial
    W_uclk = 1'b0;

  always #5 W_uclk = ~W_uclk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t ref_word(input test_mode_e mode, input word_t fixed_word,
                                     input int idx);
    word_t w;
    if (mode == MODE_WHOLE_INC || mode == MODE_PART_INC)
      w = word_t'(idx);   // low 16 bits of the burst index
    else
      w = fixed_word;
    return w;
  endfunction

  function automatic app_data_t ref_burst(input test_mode_e mode, input word_t fixed_word,
                                          input int idx);
    return {(APP_DATA_W / WORD_W){ref_word(mode, fixed_word, idx)}};
  endfunction

  function automatic app_addr_t ref_addr(input app_addr_t start_a, input int idx);
    return start_a + app_addr_t'(BURST_STEP * idx);
  endfunction

  function automatic int ref_passes(input test_mode_e mode, input app_addr_t start_a,
                                    input app_addr_t end_a);
    int span;
    int pass_span;
    int n;
    span      = int'(end_a) - int'(start_a);
    pass_span = BURSTS_PER_PASS * BURST_STEP;
    if (mode == MODE_WHOLE_INC || mode == MODE_WHOLE_FIXED)
      n = PASSES_WHOLE;
    else if (span <= 0)
      n = 1;                                     // end checked after the first pass
    else
      n = (span + pass_span - 1) / pass_span;
    return n;
  endfunction

  function automatic lane_map_t ref_lane_map(input app_data_t x);
    lane_map_t m;
    m = '0;
    for (int g = 0; g < APP_DATA_W / GROUP_W; g++)
      for (int j = 0; j < LANE_NUM; j++)
        if (x[g*GROUP_W + j*WORD_W +: WORD_W] != '0)
          m[j] = 1'b1;
    return m;
  endfunction

  function automatic int run_budget(input int passes);
    return passes * BURSTS_PER_PASS * 2 * 4 + 100;
  endfunction

  task automatic report_mismatch(input string what, input app_data_t exp_v,
                                 input app_data_t act_v);
    $display("MISMATCH %s %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
    cur_errs++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s: %s", cur_test, msg);
    cur_errs++;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    cur_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errs += cur_errs;
    if (cur_errs == 0)
      $display("test %s: ok", cur_test);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, cur_errs);
    end
  endtask

  task automatic next_cycle();
    @(posedge W_uclk);
    #1;
  endtask

  task automatic start_run(input test_mode_e mode, input word_t data,
                           input app_addr_t start_a, input app_addr_t end_a);
    exp_mode = mode;
    exp_word = data;
    exp_base = (mode == MODE_PART_INC || mode == MODE_PART_FIXED) ? start_a : '0;
    wr_seen  = 0;
    cfg      = '{mode: mode, data: data, start_addr: start_a, end_addr: end_a};
    test_en  = 1'b1;
  endtask

  // status goes TESTING, then PASS or FAIL
  task automatic wait_run_end(input int limit);
    int n;
    n = 0;
    while (test_status != STATUS_TESTING && n < limit)
    begin
      next_cycle();
      n++;
    end
    while (test_status == STATUS_TESTING && n < limit)
    begin
      next_cycle();
      n++;
    end
    if (n >= limit)
      report_error($sformatf("run did not end within %0d cycles", limit));
  endtask

  task automatic check_clean_end(input int passes);
    if (test_status !== STATUS_PASS)
      report_mismatch("status", app_data_t'(STATUS_PASS), app_data_t'(test_status));
    if (finish_cnt !== count_t'(1))
      report_mismatch("finish_cnt", app_data_t'(1), app_data_t'(finish_cnt));
    if (wr_seen != passes * BURSTS_PER_PASS)
      report_mismatch("write count", app_data_t'(passes * BURSTS_PER_PASS),
                      app_data_t'(wr_seen));
  endtask

  // every accepted write against the address and pattern rule
  always @(negedge W_uclk)
  begin
    if (!W_urst && app_req.en && app_req.cmd == CMD_WRITE && app_wdf.wren
        && app_rdy && app_wdf_rdy)
    begin
      if (wr_seen == 0)
        first_wr_addr = app_req.addr;
      if (app_req.addr !== ref_addr(exp_base, wr_seen))
        report_mismatch($sformatf("write %0d address", wr_seen),
                        app_data_t'(ref_addr(exp_base, wr_seen)), app_data_t'(app_req.addr));
      if (app_wdf.data !== ref_burst(exp_mode, exp_word, wr_seen))
        report_mismatch($sformatf("write %0d data", wr_seen),
                        ref_burst(exp_mode, exp_word, wr_seen), app_wdf.data);
      if (app_wdf.wdf_end !== 1'b1)
        report_mismatch($sformatf("write %0d wdf_end", wr_seen),
                        app_data_t'(1), app_data_t'(app_wdf.wdf_end));
      wr_seen++;
    end
  end

  always @(posedge W_uclk)
  begin
    #1;
    if (stall_on)
    begin
      lcg_state = lcg_next(lcg_state);
      stall     = {lcg_state[29:28] == 2'b00, lcg_state[31:30] == 2'b00};   // ~25% each
    end
    else
      stall = 2'b00;
  end

  initial
  begin : watchdog
    int limit;
    limit = 3 * run_budget(PASSES_WHOLE) + run_budget(ref_passes(MODE_PART_FIXED, PART_START,
            PART_END)) + run_budget(FAULT_IDX / BURSTS_PER_PASS + 1) + HOLD_CYCLES + 100;
    repeat (limit) @(posedge W_uclk);
    $display("watchdog: simulation stopped after %0d cycles", limit);
    $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin : main
    count_t t_start;
    count_t time_plain;
    count_t time_stall;
    int     passes;
    int     bad;
    W_urst       = 1'b1;
    test_en      = 1'b0;
    cfg          = '0;
    init_done    = 1'b0;
    stall        = 2'b00;
    stall_on     = 1'b0;
    lcg_state    = 32'h678d_f3a3;
    fault_addr   = '1;
    fault_xor    = '0;
    exp_mode     = MODE_WHOLE_INC;
    exp_word     = '0;
    exp_base     = '0;
    wr_seen      = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (5) next_cycle();
    W_urst = 1'b0;

    begin_test("reset");
    if (test_status !== STATUS_IDLE)
      report_mismatch("status", app_data_t'(STATUS_IDLE), app_data_t'(test_status));
    if (app_req.en !== 1'b0)
      report_mismatch("app_req.en", '0, app_data_t'(app_req.en));
    if (finish_cnt !== '0)
      report_mismatch("finish_cnt", '0, app_data_t'(finish_cnt));
    if (test_time !== '0)
      report_mismatch("test_time", '0, app_data_t'(test_time));
    end_test();
    repeat (2) next_cycle();
    init_done = 1'b1;
    next_cycle();

    begin_test("whole_inc");
    t_start = test_time;
    start_run(MODE_WHOLE_INC, 16'h0000, '0, '0);
    wait_run_end(run_budget(PASSES_WHOLE));
    check_clean_end(PASSES_WHOLE);
    time_plain = test_time - t_start;
    test_en    = 1'b0;
    if (time_plain == '0)
      report_error("test_time did not count during the run");
    end_test();
    repeat (3) next_cycle();

    begin_test("part_fixed");
    passes = ref_passes(MODE_PART_FIXED, PART_START, PART_END);
    start_run(MODE_PART_FIXED, 16'ha5c3, PART_START, PART_END);
    wait_run_end(run_budget(passes));
    check_clean_end(passes);
    test_en = 1'b0;
    if (first_wr_addr !== PART_START)
      report_mismatch("first write address", app_data_t'(PART_START),
                      app_data_t'(first_wr_addr));
    end_test();
    repeat (3) next_cycle();

    begin_test("fault_inject");
    fault_addr = ref_addr('0, FAULT_IDX);
    fault_xor  = '0;
    fault_xor[1*WORD_W +: WORD_W]             = 16'h0101;   // group 0, lane 1
    fault_xor[5*GROUP_W + 3*WORD_W +: WORD_W] = 16'h8000;   // group 5, lane 3
    passes = FAULT_IDX / BURSTS_PER_PASS + 1;
    start_run(MODE_WHOLE_INC, 16'h0000, '0, '0);
    wait_run_end(run_budget(passes));
    if (test_status !== STATUS_FAIL)
      report_mismatch("status", app_data_t'(STATUS_FAIL), app_data_t'(test_status));
    if (fail_info.addr !== fault_addr)
      report_mismatch("fail addr", app_data_t'(fault_addr), app_data_t'(fail_info.addr));
    if (fail_info.right_data !== ref_burst(MODE_WHOLE_INC, 16'h0000, FAULT_IDX))
      report_mismatch("right data", ref_burst(MODE_WHOLE_INC, 16'h0000, FAULT_IDX),
                      fail_info.right_data);
    if (fail_info.fact_data !== (ref_burst(MODE_WHOLE_INC, 16'h0000, FAULT_IDX) ^ fault_xor))
      report_mismatch("fact data", ref_burst(MODE_WHOLE_INC, 16'h0000, FAULT_IDX) ^ fault_xor,
                      fail_info.fact_data);
    if (err_lane_map !== ref_lane_map(fault_xor))
      report_mismatch("lane map", app_data_t'(ref_lane_map(fault_xor)),
                      app_data_t'(err_lane_map));
    if (wr_seen != passes * BURSTS_PER_PASS)
      report_mismatch("write count", app_data_t'(passes * BURSTS_PER_PASS),
                      app_data_t'(wr_seen));
    end_test();

    begin_test("restart");
    bad = 0;
    repeat (HOLD_CYCLES)   // enable still high from the failed run
    begin
      next_cycle();
      if (test_status !== STATUS_FAIL || app_req.en)
        bad++;
    end
    if (bad != 0)
      report_error($sformatf("run restarted or status left FAIL in %0d of %0d cycles",
                             bad, HOLD_CYCLES));
    fault_xor = '0;
    test_en   = 1'b0;
    repeat (3) next_cycle();
    if (finish_cnt !== '0)
      report_mismatch("finish_cnt while disabled", '0, app_data_t'(finish_cnt));
    start_run(MODE_WHOLE_INC, 16'h0000, '0, '0);
    wait_run_end(run_budget(PASSES_WHOLE));
    check_clean_end(PASSES_WHOLE);
    test_en = 1'b0;
    end_test();
    repeat (3) next_cycle();

    begin_test("stall");
    stall_on = 1'b1;
    t_start  = test_time;
    start_run(MODE_WHOLE_INC, 16'h0000, '0, '0);
    wait_run_end(run_budget(PASSES_WHOLE));
    check_clean_end(PASSES_WHOLE);
    time_stall = test_time - t_start;
    test_en    = 1'b0;
    stall_on   = 1'b0;
    if (time_stall <= time_plain)
      report_error($sformatf("test_time %0d with stalls is not above %0d without",
                             time_stall, time_plain));
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (tests_failed == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- testbench/app_mem_model.sv
`timescale 1ns/1ps

module app_mem_model
(
  input  logic                    W_uclk,
  input  logic                    W_urst,
  input  selftest_pkg::app_req_t  app_req,
  input  selftest_pkg::app_wdf_t  app_wdf,
  output logic                    app_rdy,
  output logic                    app_wdf_rdy,
  output selftest_pkg::app_rsp_t  app_rsp,
  input  logic [1:0]              stall,        // bit 0 drops rdy, bit 1 drops wdf_rdy
  input  selftest_pkg::app_addr_t fault_addr,
  input  selftest_pkg::app_data_t fault_xor
);
  import selftest_pkg::*;

  app_data_t mem [app_addr_t];   // one burst per address
  app_rsp_t  rsp_d1;
  app_rsp_t  rsp_d2;

  assign app_rdy     = !stall[0];
  assign app_wdf_rdy = !stall[1];

  // fixed three cycle read latency, returns in issue order
  always @(posedge W_uclk)
  begin : port_logic
    app_rsp_t rsp;
    rsp = '0;
    if (W_urst)
    begin
      rsp_d1  <= '0;
      rsp_d2  <= '0;
      app_rsp <= '0;
    end
    else
    begin
      if (app_req.en && app_rdy)
      begin
        if (app_req.cmd == CMD_WRITE && app_wdf.wren && app_wdf_rdy)
          mem[app_req.addr] = app_wdf.data;
        else if (app_req.cmd == CMD_READ)
        begin
          rsp.rd_valid = 1'b1;
          rsp.rd_data  = mem.exists(app_req.addr) ? mem[app_req.addr] : '0;
          if (app_req.addr == fault_addr)
            rsp.rd_data = rsp.rd_data ^ fault_xor;   // injected bit errors
        end
      end
      rsp_d1  <= rsp;
      rsp_d2  <= rsp_d1;
      app_rsp <= rsp_d2;
    end
  end

endmodule

//--- testbench/selftest_checker.sv
`timescale 1ns/1ps

module selftest_checker
(
  input logic                   W_uclk,
  input logic                   W_urst,
  input selftest_pkg::st_e      state,
  input logic                   fail,
  input selftest_pkg::app_req_t app_req,
  input selftest_pkg::app_wdf_t app_wdf,
  input logic                   app_rdy,
  input logic                   app_wdf_rdy
);
  import selftest_pkg::*;

  logic acc;

  assign acc = (app_req.cmd == CMD_WRITE) ? (app_rdy && app_wdf_rdy) : app_rdy;

  // a fail may cut a waiting read short
  hold_until_accepted: assert property (@(posedge W_uclk) disable iff (W_urst)
    app_req.en && !acc |=> fail || (app_req.en && $stable(app_req.addr)
                                     && $stable(app_req.cmd) && $stable(app_wdf.data)))
    else $error("command dropped or changed before it was accepted");

  wren_follows_en: assert property (@(posedge W_uclk) disable iff (W_urst)
    app_wdf.wren == (app_req.en && app_req.cmd == CMD_WRITE))
    else $error("wren does not match a pending write command");

  quiet_in_idle: assert property (@(posedge W_uclk) disable iff (W_urst)
    (state == IDLE) |-> !app_req.en)
    else $error("command issued while idle");

endmodule

//--- source/ddr_selftest.sv
`timescale 1ns/1ps

module ddr_selftest
(
  input  logic                       W_uclk,
  input  logic                       W_urst,
  input  logic                       test_en,
  input  selftest_pkg::test_cfg_t    cfg,
  input  logic                       init_done,
  output selftest_pkg::app_req_t     app_req,
  output selftest_pkg::app_wdf_t     app_wdf,
  input  logic                       app_rdy,
  input  logic                       app_wdf_rdy,
  input  selftest_pkg::app_rsp_t     app_rsp,
  output selftest_pkg::test_status_e test_status,
  output selftest_pkg::fail_info_t   fail_info,
  output selftest_pkg::lane_map_t    err_lane_map,
  output selftest_pkg::count_t       test_time,
  output selftest_pkg::count_t       finish_cnt
);
  import selftest_pkg::*;

  st_e       state;
  test_cfg_t cfg_lat;      // cfg held for the run
  app_addr_t base_addr;
  logic      pass_wr_done;
  logic      pass_rd_done;
  logic      fail;

  selftest_ctrl ctrl0
  (
    .W_uclk       (W_uclk),
    .W_urst       (W_urst),
    .test_en      (test_en),
    .cfg_in       (cfg),
    .init_done    (init_done),
    .pass_wr_done (pass_wr_done),
    .pass_rd_done (pass_rd_done),
    .fail         (fail),
    .state        (state),
    .cfg          (cfg_lat),
    .base_addr    (base_addr),
    .test_status  (test_status),
    .test_time    (test_time),
    .finish_cnt   (finish_cnt)
  );

  selftest_cmd cmd0
  (
    .W_uclk         (W_uclk),
    .W_urst         (W_urst),
    .state          (state),
    .cfg            (cfg_lat),
    .base_addr      (base_addr),
    .app_rdy        (app_rdy),
    .app_wdf_rdy    (app_wdf_rdy),
    .fail           (fail),
    .app_req        (app_req),
    .app_wdf        (app_wdf),
    .pass_wr_done   (pass_wr_done),
    .pass_rd_issued ()   // read pass ends on the last return, not on issue
  );

  selftest_check check0
  (
    .W_uclk       (W_uclk),
    .W_urst       (W_urst),
    .state        (state),
    .cfg          (cfg_lat),
    .base_addr    (base_addr),
    .app_rsp      (app_rsp),
    .pass_rd_done (pass_rd_done),
    .fail         (fail),
    .fail_info    (fail_info),
    .err_lane_map (err_lane_map)
  );

endmodule

//--- source/selftest_check.sv
`timescale 1ns/1ps

module selftest_check
(
  input  logic                    W_uclk,
  input  logic                    W_urst,
  input  selftest_pkg::st_e       state,
  input  selftest_pkg::test_cfg_t cfg,
  input  selftest_pkg::app_addr_t base_addr,
  input  selftest_pkg::app_rsp_t  app_rsp,
  output logic                    pass_rd_done,
  output logic                    fail,
  output selftest_pkg::fail_info_t fail_info,
  output selftest_pkg::lane_map_t err_lane_map
);
  import selftest_pkg::*;

  logic       rsp_vld;
  logic       mismatch;
  burst_idx_t rd_cnt;     // returns in this pass
  burst_idx_t rd_idx;     // burst index within the run
  app_addr_t  exp_addr;
  app_data_t  exp_data;
  lane_map_t  lane_diff;

  assign rsp_vld  = app_rsp.rd_valid && !fail;   // late returns after a fail ignored
  assign exp_data = {(APP_DATA_W / WORD_W){pattern_word(cfg.mode, cfg.data, rd_idx)}};
  assign mismatch = rsp_vld && (app_rsp.rd_data != exp_data);

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      rd_cnt <= '0;
    else if (state == START || state == READ_END)
      rd_cnt <= '0;
    else if (rsp_vld)
      rd_cnt <= rd_cnt + 1'b1;
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
    begin
      rd_idx   <= '0;
      exp_addr <= '0;
    end
    else if (state == START)
    begin
      rd_idx   <= '0;
      exp_addr <= base_addr;
    end
    else if (rsp_vld)
    begin
      rd_idx   <= rd_idx + 1'b1;
      exp_addr <= exp_addr + app_addr_t'(BURST_STEP);
    end
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      pass_rd_done <= 1'b0;
    else
      pass_rd_done <= rsp_vld && (rd_cnt == burst_idx_t'(BURSTS_PER_PASS - 1));
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      fail <= 1'b0;
    else if (state == START)
      fail <= 1'b0;
    else if (mismatch)
      fail <= 1'b1;   // sticky until next run
  end

  // first mismatch only, rsp_vld is blocked once fail is set
  always_ff @(posedge W_uclk)
  begin
    if (state == START)
      fail_info <= '0;
    else if (mismatch)
    begin
      fail_info.addr       <= exp_addr;
      fail_info.right_data <= exp_data;
      fail_info.fact_data  <= app_rsp.rd_data;
    end
  end

  // lane j is bad if it differs in any 64-bit group
  always_comb
  begin
    lane_diff = '0;
    for (int g = 0; g < APP_DATA_W / GROUP_W; g++)
    begin
      for (int j = 0; j < LANE_NUM; j++)
      begin
        if (fail_info.right_data[g*GROUP_W + j*WORD_W +: WORD_W] !=
            fail_info.fact_data[g*GROUP_W + j*WORD_W +: WORD_W])
          lane_diff[j] = 1'b1;
      end
    end
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      err_lane_map <= '0;
    else if (state == START)
      err_lane_map <= '0;
    else
      err_lane_map <= lane_diff;   // one cycle behind fail_info
  end

endmodule

//--- source/selftest_cmd.sv
`timescale 1ns/1ps

module selftest_cmd
(
  input  logic                    W_uclk,
  input  logic                    W_urst,
  input  selftest_pkg::st_e       state,
  input  selftest_pkg::test_cfg_t cfg,
  input  selftest_pkg::app_addr_t base_addr,
  input  logic                    app_rdy,
  input  logic                    app_wdf_rdy,
  input  logic                    fail,
  output selftest_pkg::app_req_t  app_req,
  output selftest_pkg::app_wdf_t  app_wdf,
  output logic                    pass_wr_done,
  output logic                    pass_rd_issued
);
  import selftest_pkg::*;

  logic       wr_phase;
  logic       rd_phase;
  logic       cmd_en;
  logic       wr_acc;
  logic       rd_acc;
  logic       last_cmd;
  burst_idx_t issue_cnt;   // commands accepted in this pass
  burst_idx_t wr_idx;      // burst index of the next write
  app_addr_t  wr_addr;
  app_addr_t  rd_addr;
  word_t      wr_word;

  assign wr_phase = (state == WRITE);
  assign rd_phase = (state == READ) && !fail;   // no new reads after a fail
  assign cmd_en   = (wr_phase || rd_phase) && (issue_cnt < burst_idx_t'(BURSTS_PER_PASS));
  assign wr_acc   = cmd_en && wr_phase && app_rdy && app_wdf_rdy;
  assign rd_acc   = cmd_en && rd_phase && app_rdy;
  assign last_cmd = (issue_cnt == burst_idx_t'(BURSTS_PER_PASS - 1));
  assign wr_word  = pattern_word(cfg.mode, cfg.data, wr_idx);

  // en, addr, cmd and data only move on acceptance
  assign app_req = '{
    en:   cmd_en,
    cmd:  (state == READ) ? CMD_READ : CMD_WRITE,
    addr: (state == READ) ? rd_addr : wr_addr
  };

  assign app_wdf = '{
    wren:    cmd_en && wr_phase,   // single beat per burst
    wdf_end: cmd_en && wr_phase,
    data:    {(APP_DATA_W / WORD_W){wr_word}}
  };

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      issue_cnt <= '0;
    else if (state == START || state == WRITE_END || state == READ_END)
      issue_cnt <= '0;
    else if (wr_acc || rd_acc)
      issue_cnt <= issue_cnt + 1'b1;
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      wr_addr <= '0;
    else if (state == START)
      wr_addr <= base_addr;
    else if (wr_acc)
      wr_addr <= wr_addr + app_addr_t'(BURST_STEP);   // runs on across passes
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      rd_addr <= '0;
    else if (state == START)
      rd_addr <= base_addr;
    else if (rd_acc)
      rd_addr <= rd_addr + app_addr_t'(BURST_STEP);
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      wr_idx <= '0;
    else if (state == START)
      wr_idx <= '0;
    else if (wr_acc)
      wr_idx <= wr_idx + 1'b1;
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
    begin
      pass_wr_done   <= 1'b0;
      pass_rd_issued <= 1'b0;
    end
    else
    begin
      pass_wr_done   <= wr_acc && last_cmd;
      pass_rd_issued <= rd_acc && last_cmd;
    end
  end

endmodule

//--- source/selftest_ctrl.sv
`timescale 1ns/1ps

module selftest_ctrl
(
  input  logic                       W_uclk,
  input  logic                       W_urst,
  input  logic                       test_en,
  input  selftest_pkg::test_cfg_t    cfg_in,
  input  logic                       init_done,
  input  logic                       pass_wr_done,
  input  logic                       pass_rd_done,
  input  logic                       fail,
  output selftest_pkg::st_e          state,
  output selftest_pkg::test_cfg_t    cfg,
  output selftest_pkg::app_addr_t    base_addr,
  output selftest_pkg::test_status_e test_status,
  output selftest_pkg::count_t       test_time,
  output selftest_pkg::count_t       finish_cnt
);
  import selftest_pkg::*;

  st_e        nxt_state;
  logic       test_en_d1;
  logic       en_rise;
  logic       start_ok;
  logic       part_mode;
  logic       run_done;
  logic       finish_pend;   // run ended clean, keeps PASS in idle
  burst_idx_t pass_cnt;
  app_addr_t  pass_end_addr;

  assign en_rise   = test_en && !test_en_d1;
  assign part_mode = (cfg.mode == MODE_PART_INC) || (cfg.mode == MODE_PART_FIXED);
  assign base_addr = part_mode ? cfg.start_addr : '0;   // cfg frozen outside idle

  // a failed run needs a fresh enable edge
  assign start_ok = init_done && (fail ? en_rise : test_en);

  assign pass_end_addr = base_addr
                       + app_addr_t'(pass_cnt) * app_addr_t'(BURSTS_PER_PASS * BURST_STEP);
  assign run_done = part_mode ? (pass_end_addr >= cfg.end_addr)
                              : (pass_cnt >= burst_idx_t'(PASSES_WHOLE));

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb
  begin
    nxt_state = state;
    case (state)
      IDLE:
      begin
        if (start_ok)
          nxt_state = START;
      end
      START:
        nxt_state = WRITE;
      WRITE:
      begin
        if (pass_wr_done)
          nxt_state = WRITE_END;
      end
      WRITE_END:
        nxt_state = READ;
      READ:
      begin
        if (fail)
          nxt_state = FINISH;   // stop on first fail
        else if (pass_rd_done)
          nxt_state = READ_END;
      end
      READ_END:
        nxt_state = run_done ? FINISH : WRITE;
      default:
        nxt_state = IDLE;
    endcase
  end

  always_ff @(posedge W_uclk)
  begin
    if (state == IDLE)
      cfg <= cfg_in;
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      test_en_d1 <= 1'b0;
    else
      test_en_d1 <= test_en;
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      pass_cnt <= '0;
    else if (state == START)
      pass_cnt <= '0;
    else if (state == WRITE_END)
      pass_cnt <= pass_cnt + 1'b1;   // passes written so far
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      finish_pend <= 1'b0;
    else if (state == START)
      finish_pend <= 1'b0;
    else if (state == READ_END && run_done)
      finish_pend <= 1'b1;
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      test_status <= STATUS_IDLE;
    else
    begin
      case (state)
        IDLE:
        begin
          if (!finish_pend && !fail)
            test_status <= STATUS_IDLE;
        end
        FINISH:
          test_status <= fail ? STATUS_FAIL : STATUS_PASS;
        default:
          test_status <= STATUS_TESTING;
      endcase
    end
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      test_time <= '0;
    else if (test_status == STATUS_IDLE)
      test_time <= '0;
    else if (test_status == STATUS_TESTING)
      test_time <= test_time + 1'b1;   // held once pass/fail
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      finish_cnt <= '0;
    else if (!test_en)
      finish_cnt <= '0;
    else if (state == FINISH)
      finish_cnt <= finish_cnt + 1'b1;
  end

endmodule

//--- common/selftest_pkg.sv
package selftest_pkg;

  localparam int APP_ADDR_W      = 29;
  localparam int APP_DATA_W      = 512;
  localparam int WORD_W          = 16;
  localparam int LANE_NUM        = 4;    // 16-bit lanes per 64-bit group
  localparam int GROUP_W         = 64;
  localparam int BURST_STEP      = 8;    // address step per burst
  localparam int BURSTS_PER_PASS = 16;
  localparam int PASSES_WHOLE    = 4;
  localparam int TIME_W          = 32;

  localparam logic [2:0] CMD_WRITE = 3'd0;
  localparam logic [2:0] CMD_READ  = 3'd1;

  typedef logic [APP_ADDR_W-1:0] app_addr_t;
  typedef logic [APP_DATA_W-1:0] app_data_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [LANE_NUM-1:0]   lane_map_t;   // bit j set, lane j failed
  typedef logic [TIME_W-1:0]     count_t;
  typedef logic [15:0]           burst_idx_t;

  typedef enum logic [1:0] {
    MODE_WHOLE_INC   = 2'd0,
    MODE_WHOLE_FIXED = 2'd1,
    MODE_PART_INC    = 2'd2,
    MODE_PART_FIXED  = 2'd3
  } test_mode_e;

  typedef enum logic [1:0] {
    STATUS_IDLE    = 2'd0,
    STATUS_TESTING = 2'd1,
    STATUS_PASS    = 2'd2,
    STATUS_FAIL    = 2'd3
  } test_status_e;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    START     = 3'd1,
    WRITE     = 3'd2,
    WRITE_END = 3'd3,
    READ      = 3'd4,
    READ_END  = 3'd5,
    FINISH    = 3'd6
  } st_e;

  typedef struct packed {
    test_mode_e mode;
    word_t      data;         // fixed pattern word
    app_addr_t  start_addr;   // part mode only, multiple of 8
    app_addr_t  end_addr;
  } test_cfg_t;

  typedef struct packed {
    logic       en;
    logic [2:0] cmd;
    app_addr_t  addr;
  } app_req_t;

  typedef struct packed {
    logic      wren;
    logic      wdf_end;
    app_data_t data;
  } app_wdf_t;

  typedef struct packed {
    logic      rd_valid;
    app_data_t rd_data;
  } app_rsp_t;

  typedef struct packed {
    app_addr_t addr;
    app_data_t right_data;
    app_data_t fact_data;
  } fail_info_t;

  // word written to and expected from burst number idx of a run
  function automatic word_t pattern_word(input test_mode_e mode,
                                         input word_t      fixed_word,
                                         input burst_idx_t idx);
    word_t w;
    if (mode == MODE_WHOLE_INC || mode == MODE_PART_INC)
      w = idx[WORD_W-1:0];
    else
      w = fixed_word;
    return w;
  endfunction

endpackage
